//--- design/panel_pkg.sv
/*
 * Front-panel encodings shared by the control and display logic.
 * Segments are active high with bit 0 = a and bit 6 = g.
 */
`default_nettype none

package panel_pkg;

    // Main state, numbered as the DIP switches select it
    typedef enum logic [2:0] {
        MODE_MENU     = 3'd0,
        MODE_INPUT    = 3'd1,
        MODE_GENERATE = 3'd2,
        MODE_DISPLAY  = 3'd3,
        MODE_COMPUTE  = 3'd4,
        MODE_SETTING  = 3'd5
    } mode_t;

    localparam int SEL_WIDTH = 3;
    localparam int ERR_WIDTH = 4;
    localparam logic [ERR_WIDTH-1:0] ERR_NONE = '0;

    // ==================================================================
    // Seven-segment table
    // ==================================================================
    localparam int SEG_WIDTH = 7;
    localparam logic [3:0] DIGIT_E     = 4'd14;
    localparam logic [3:0] DIGIT_BLANK = 4'd15;

    localparam logic [SEG_WIDTH-1:0] seg_digit [16] = '{
        7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
        7'h7F, 7'h6F, 7'h00, 7'h00, 7'h00, 7'h00, 7'h79, 7'h00
    };

endpackage

`default_nettype wire

//--- design/timing_pkg.sv
/*
 * Board timing. Values assume the 100 MHz board oscillator.
 */
`default_nettype none

package timing_pkg;

    localparam int CLK_FREQ          = 100_000_000;
    localparam int COUNTDOWN_SECONDS = 7;
    localparam int DEBOUNCE_MS       = 20;

    // Defaults for the top-level parameters
    localparam int DEBOUNCE_TICKS_DEFAULT   = (CLK_FREQ / 1000) * DEBOUNCE_MS;
    localparam int TICKS_PER_SECOND_DEFAULT = CLK_FREQ;

endpackage

`default_nettype wire

//--- design/button_debounce.sv
/*
 * Raw button in, one-cycle press pulse out. Both press and release must
 * stay stable for DEBOUNCE_TICKS cycles; latency is about DEBOUNCE_TICKS+3.
 */
`timescale 1ns/1ps
`default_nettype none

module button_debounce import timing_pkg::*; #(
    parameter int DEBOUNCE_TICKS = DEBOUNCE_TICKS_DEFAULT
) (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  btn,
    output logic press
);

    localparam int CNT_W = (DEBOUNCE_TICKS > 1) ? $clog2(DEBOUNCE_TICKS) : 1;

    logic             btn_meta;
    logic             btn_sync;
    logic             btn_state;
    logic [CNT_W-1:0] stable_cnt;
    logic             changing;

    // Two-flop synchronizer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            btn_meta <= 1'b0;
            btn_sync <= 1'b0;
        end else begin
            btn_meta <= btn;
            btn_sync <= btn_meta;
        end
    end

    assign changing = (btn_sync != btn_state);

    // Accepted level flips once the new level has held long enough
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            btn_state  <= 1'b0;
            stable_cnt <= '0;
            press      <= 1'b0;
        end else begin
            press <= 1'b0;
            if (!changing) begin
                stable_cnt <= '0;
            end else if (stable_cnt == CNT_W'(DEBOUNCE_TICKS - 1)) begin
                stable_cnt <= '0;
                btn_state  <= btn_sync;
                // Only the rising edge is a press
                press      <= btn_sync;
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/mode_control.sv
/*
 * Main menu FSM. DIP values 1..5 pick a mode, others keep the menu.
 * The error code is ignored while in the menu.
 */
`timescale 1ns/1ps
`default_nettype none

module mode_control import panel_pkg::*; (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire [SEL_WIDTH-1:0]  dip_sw,
    input  wire                  confirm,
    input  wire                  back,
    input  wire [ERR_WIDTH-1:0]  error_code,
    output mode_t                mode,
    output logic                 mode_confirm,
    output logic                 error_active
);

    mode_t mode_next;

    // ==================================================================
    // Next-state logic
    // ==================================================================
    always_comb begin
        mode_next = mode;
        if (mode == MODE_MENU) begin
            if (confirm) begin
                case (dip_sw)
                    SEL_WIDTH'(1): mode_next = MODE_INPUT;
                    SEL_WIDTH'(2): mode_next = MODE_GENERATE;
                    SEL_WIDTH'(3): mode_next = MODE_DISPLAY;
                    SEL_WIDTH'(4): mode_next = MODE_COMPUTE;
                    SEL_WIDTH'(5): mode_next = MODE_SETTING;
                    default:       mode_next = MODE_MENU;
                endcase
            end
        end else if (back) begin
            mode_next = MODE_MENU;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode <= MODE_MENU;
        end else begin
            mode <= mode_next;
        end
    end

    // Confirm in a mode belongs to that mode's logic, one cycle later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode_confirm <= 1'b0;
        end else begin
            mode_confirm <= confirm && (mode != MODE_MENU);
        end
    end

    // ==================================================================
    // Error gating
    // ==================================================================
    assign error_active = (mode != MODE_MENU) && (error_code != ERR_NONE);

endmodule

`default_nettype wire

//--- design/error_countdown.sv
/*
 * Error countdown: digit falls from COUNTDOWN_SECONDS to 1 while an error
 * stands, then one timeout cycle with digit 0 and lamp off. A standing
 * error restarts the count; dropping the error clears it.
 */
`timescale 1ns/1ps
`default_nettype none

module error_countdown import timing_pkg::*; #(
    parameter int TICKS_PER_SECOND = TICKS_PER_SECOND_DEFAULT
) (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        error_active,
    output logic [3:0] countdown,
    output logic       error_lamp,
    output logic       timeout
);

    localparam int TICK_W = (TICKS_PER_SECOND > 1) ? $clog2(TICKS_PER_SECOND) : 1;
    localparam int SEC_W  = $clog2(COUNTDOWN_SECONDS + 1);

    logic [TICK_W-1:0] tick_cnt;
    logic [SEC_W-1:0]  sec_cnt;
    logic              second_done;
    logic              expired;

    assign second_done = (tick_cnt == TICK_W'(TICKS_PER_SECOND - 1));
    assign expired     = (sec_cnt == SEC_W'(COUNTDOWN_SECONDS));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt   <= '0;
            sec_cnt    <= '0;
            countdown  <= 4'(COUNTDOWN_SECONDS);
            error_lamp <= 1'b0;
            timeout    <= 1'b0;
        end else if (!error_active) begin
            tick_cnt   <= '0;
            sec_cnt    <= '0;
            countdown  <= 4'(COUNTDOWN_SECONDS);
            error_lamp <= 1'b0;
            timeout    <= 1'b0;
        end else if (expired) begin
            // Single timeout cycle, then start over
            tick_cnt   <= '0;
            sec_cnt    <= '0;
            countdown  <= 4'd0;
            error_lamp <= 1'b0;
            timeout    <= 1'b1;
        end else begin
            countdown  <= 4'(COUNTDOWN_SECONDS - int'(sec_cnt));
            error_lamp <= 1'b1;
            timeout    <= 1'b0;
            if (second_done) begin
                tick_cnt <= '0;
                sec_cnt  <= sec_cnt + 1'b1;
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/status_display.sv
/*
 * Registered panel outputs, one cycle behind their inputs.
 * A timeout is seen here as lamp off with countdown 0.
 */
`timescale 1ns/1ps
`default_nettype none

module status_display import panel_pkg::*; (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire mode_t           mode,
    input  wire                  error_lamp,
    input  wire [3:0]            countdown,
    output logic [SEG_WIDTH-1:0] seg_display,
    output logic [SEG_WIDTH-1:0] seg_countdown,
    output logic [3:0]           led_status
);

    logic [3:0] display_idx;
    logic [3:0] countdown_idx;
    logic       show_countdown;

    // ==================================================================
    // Digit selection
    // ==================================================================
    assign display_idx    = error_lamp ? DIGIT_E : {1'b0, mode};
    assign show_countdown = error_lamp || (countdown == 4'd0);
    assign countdown_idx  = show_countdown ? countdown : DIGIT_BLANK;

    // ==================================================================
    // Output registers
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seg_display   <= seg_digit[0];
            seg_countdown <= seg_digit[DIGIT_BLANK];
            led_status    <= 4'd0;
        end else begin
            seg_display   <= seg_digit[display_idx];
            seg_countdown <= seg_digit[countdown_idx];
            // Lamp on bit 3, mode number below it
            led_status    <= {error_lamp, mode};
        end
    end

endmodule

`default_nettype wire

//--- design/front_panel_top.sv
/*
 * Front-panel control top. Buttons are raw and active high.
 * Mode logic outside uses mode, mode_confirm and mode_reset.
 */
`timescale 1ns/1ps
`default_nettype none

module front_panel_top import panel_pkg::*, timing_pkg::*; #(
    parameter int DEBOUNCE_TICKS   = DEBOUNCE_TICKS_DEFAULT,
    parameter int TICKS_PER_SECOND = TICKS_PER_SECOND_DEFAULT
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire [SEL_WIDTH-1:0]  dip_sw,
    input  wire                  btn_confirm,
    input  wire                  btn_back,
    input  wire [ERR_WIDTH-1:0]  error_code,
    output mode_t                mode,
    output logic                 mode_confirm,
    output logic                 mode_reset,
    output logic [SEG_WIDTH-1:0] seg_display,
    output logic [SEG_WIDTH-1:0] seg_countdown,
    output logic [3:0]           led_status
);

    logic       confirm_pulse;
    logic       back_pulse;
    logic       error_active;
    logic       error_lamp;
    logic [3:0] countdown;

    // ==================================================================
    // Buttons
    // ==================================================================
    button_debounce #(.DEBOUNCE_TICKS(DEBOUNCE_TICKS)) u_db_confirm (
        .clk   (clk),
        .rst_n (rst_n),
        .btn   (btn_confirm),
        .press (confirm_pulse)
    );

    button_debounce #(.DEBOUNCE_TICKS(DEBOUNCE_TICKS)) u_db_back (
        .clk   (clk),
        .rst_n (rst_n),
        .btn   (btn_back),
        .press (back_pulse)
    );

    // ==================================================================
    // Control, countdown and display
    // ==================================================================
    mode_control u_mode_control (
        .clk          (clk),
        .rst_n        (rst_n),
        .dip_sw       (dip_sw),
        .confirm      (confirm_pulse),
        .back         (back_pulse),
        .error_code   (error_code),
        .mode         (mode),
        .mode_confirm (mode_confirm),
        .error_active (error_active)
    );

    error_countdown #(.TICKS_PER_SECOND(TICKS_PER_SECOND)) u_error_countdown (
        .clk          (clk),
        .rst_n        (rst_n),
        .error_active (error_active),
        .countdown    (countdown),
        .error_lamp   (error_lamp),
        .timeout      (mode_reset)
    );

    status_display u_status_display (
        .clk           (clk),
        .rst_n         (rst_n),
        .mode          (mode),
        .error_lamp    (error_lamp),
        .countdown     (countdown),
        .seg_display   (seg_display),
        .seg_countdown (seg_countdown),
        .led_status    (led_status)
    );

endmodule

`default_nettype wire

//--- sim/tb_clock_gen.sv
/*
 * Testbench clock with a 20 ns period. rst_n is released 2 ns after
 * the second rising edge.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #2 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- sim/front_panel_sva.sv
/*
 * Mode FSM properties, bound into mode_control.
 * assert_failures counts failed assertions for the testbench summary.
 */
`timescale 1ns/1ps
`default_nettype none

module front_panel_sva import panel_pkg::*; (
    input wire        clk,
    input wire        rst_n,
    input wire        confirm,
    input wire        back,
    input wire mode_t mode,
    input wire        mode_confirm
);

    int assert_failures = 0;

    // Leaving the menu takes a confirm pulse
    assert property (@(posedge clk) disable iff (!rst_n)
        (mode == MODE_MENU && !confirm) |=> (mode == MODE_MENU))
    else begin
        assert_failures++;
        $error("mode left the menu without a confirm pulse");
    end

    // Back to the menu only after a back pulse
    assert property (@(posedge clk) disable iff (!rst_n)
        (mode != MODE_MENU && !back) |=> (mode != MODE_MENU))
    else begin
        assert_failures++;
        $error("mode returned to the menu without a back pulse");
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (mode == MODE_MENU) |=> !mode_confirm)
    else begin
        assert_failures++;
        $error("mode_confirm rose while in the menu");
    end

endmodule

bind mode_control front_panel_sva u_mode_sva (
    .clk          (clk),
    .rst_n        (rst_n),
    .confirm      (confirm),
    .back         (back),
    .mode         (mode),
    .mode_confirm (mode_confirm)
);

`default_nettype wire

//--- sim/front_panel_tb.sv
/*
 * Testbench for front_panel_top with DEBOUNCE_TICKS 4 and TICKS_PER_SECOND 8.
 * Inputs change 2 ns after the rising edge, outputs are sampled on the falling edge.
 */
`timescale 1ns/1ps
`default_nettype none

module front_panel_tb import panel_pkg::*; ();

    localparam int LIMIT = 200;
    // Segment patterns, bit 0 = a, index 14 = E, others blank
    localparam logic [6:0] segs_ref [16] = '{
        7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
        7'h7F, 7'h6F, 7'h00, 7'h00, 7'h00, 7'h00, 7'h79, 7'h00
    };

    logic                 clk;
    logic                 rst_n;
    logic [SEL_WIDTH-1:0] dip_sw;
    logic                 btn_confirm;
    logic                 btn_back;
    logic [ERR_WIDTH-1:0] error_code;
    mode_t                mode;
    logic                 mode_confirm;
    logic                 mode_reset;
    logic [SEG_WIDTH-1:0] seg_display;
    logic [SEG_WIDTH-1:0] seg_countdown;
    logic [3:0]           led_status;

    int          errors;
    int          test_errors;
    int          tests_run;
    int          checks;
    int          confirm_pulses;
    int          reset_pulses;
    logic [31:0] lcg_state;
    string       test_name;
    logic        compare_en;
    logic [2:0]  exp_mode;

    tb_clock_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    front_panel_top #(.DEBOUNCE_TICKS(4), .TICKS_PER_SECOND(8)) u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .dip_sw        (dip_sw),
        .btn_confirm   (btn_confirm),
        .btn_back      (btn_back),
        .error_code    (error_code),
        .mode          (mode),
        .mode_confirm  (mode_confirm),
        .mode_reset    (mode_reset),
        .seg_display   (seg_display),
        .seg_countdown (seg_countdown),
        .led_status    (led_status)
    );

    // ==================================================================
    // Reference model
    // ==================================================================
    // Packed as {seg_display, seg_countdown, led_status}
    function automatic logic [17:0] expected_outputs(input logic [2:0] m, input logic lamp,
                                                     input logic [3:0] digit);
        logic [6:0] disp;
        logic [6:0] cnt;
        disp = lamp ? segs_ref[14] : segs_ref[{1'b0, m}];
        cnt  = (lamp || digit == 4'd0) ? segs_ref[digit] : segs_ref[15];
        return {disp, cnt, lamp, m};
    endfunction

    function automatic logic [2:0] expected_mode(input logic [2:0] sw);
        return (sw >= 3'd1 && sw <= 3'd5) ? sw : 3'd0;
    endfunction

    function automatic logic [2:0] next_switch();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[18:16];
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            test_errors++;
            $display("CHECK FAILED %s/%s: expected 0x%0h, actual 0x%0h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic abort_run(input string what);
        $display("TIMEOUT in %s: %s never came", test_name, what);
        $display("tests failed");
        $finish;
    endtask

    task automatic next_slot();
        @(posedge clk);
        #2;
    endtask

    task automatic press_button(input bit is_back);
        next_slot();
        if (is_back) begin
            btn_back = 1'b1;
        end else begin
            btn_confirm = 1'b1;
        end
        repeat (10) next_slot();
        btn_back    = 1'b0;
        btn_confirm = 1'b0;
        repeat (10) next_slot();
    endtask

    task automatic wait_for_mode(input logic [2:0] target);
        int n;
        n = 0;
        while (mode !== target && n < LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (mode !== target) abort_run($sformatf("mode %0d", target));
        next_slot();
    endtask

    // Display lags by a cycle, so let it settle before comparing
    task automatic compare_for(input int cycles);
        repeat (2) next_slot();
        compare_en = 1'b1;
        repeat (cycles) next_slot();
        compare_en = 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("%-18s ok", test_name);
        end else begin
            $display("%-18s %0d errors", test_name, test_errors);
        end
    endtask

    // ==================================================================
    // Comparison and pulse counting
    // ==================================================================
    // Outside an error the lamp is off and the countdown idles at 7
    always @(negedge clk) begin
        logic [17:0] want;
        if (compare_en) begin
            want = expected_outputs(exp_mode, 1'b0, 4'd7);
            check_value("mode", exp_mode, mode);
            check_value("seg_display", want[17:11], seg_display);
            check_value("seg_countdown", want[10:4], seg_countdown);
            check_value("led_status", want[3:0], led_status);
        end
    end

    always @(negedge clk) begin
        if (mode_confirm === 1'b1) confirm_pulses++;
        if (mode_reset === 1'b1) reset_pulses++;
    end

    // ==================================================================
    // Stimulus
    // ==================================================================
    initial begin
        int         start_count;
        int         n;
        logic [2:0] sw;
        logic [6:0] seen [$];
        logic [6:0] last_seg;
        logic [17:0] want;
        bit         reset_prev;
        errors         = 0;
        test_errors    = 0;
        tests_run      = 0;
        checks         = 0;
        confirm_pulses = 0;
        reset_pulses   = 0;
        lcg_state      = 32'd33;
        dip_sw         = '0;
        btn_confirm    = 1'b0;
        btn_back       = 1'b0;
        error_code     = ERR_NONE;
        compare_en     = 1'b0;
        exp_mode       = 3'd0;

        start_test("reset_state");
        n = 0;
        while (rst_n !== 1'b1 && n < LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (rst_n !== 1'b1) abort_run("reset release");
        check_value("mode_confirm", 0, mode_confirm);
        check_value("mode_reset", 0, mode_reset);
        next_slot();
        compare_for(3);
        end_test();

        start_test("mode_select");
        for (int i = 0; i < 20; i++) begin
            sw     = next_switch();
            dip_sw = sw;
            press_button(1'b0);
            wait_for_mode(expected_mode(sw));
            exp_mode = expected_mode(sw);
            compare_for(3);
            if (exp_mode != 3'd0) begin
                press_button(1'b1);
                wait_for_mode(3'd0);
                exp_mode = 3'd0;
                compare_for(3);
            end
        end
        end_test();

        start_test("confirm_forward");
        dip_sw = 3'd3;
        press_button(1'b0);
        wait_for_mode(3'd3);
        start_count = confirm_pulses;
        dip_sw      = 3'd1;
        press_button(1'b0);
        n = 0;
        while (confirm_pulses == start_count && n < LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (confirm_pulses == start_count) abort_run("mode_confirm pulse");
        repeat (10) next_slot();
        check_value("pulse count", 1, confirm_pulses - start_count);
        check_value("mode kept", 3, mode);
        press_button(1'b1);
        wait_for_mode(3'd0);
        dip_sw      = 3'd0;
        start_count = confirm_pulses;
        press_button(1'b0);
        repeat (10) next_slot();
        check_value("menu pulse count", 0, confirm_pulses - start_count);
        check_value("menu kept", 0, mode);
        end_test();

        // Expect 7 down to 0, then the restart at 7
        start_test("error_countdown");
        dip_sw = 3'd2;
        press_button(1'b0);
        wait_for_mode(3'd2);
        start_count = reset_pulses;
        error_code  = 4'h5;
        last_seg    = segs_ref[15];
        reset_prev  = 1'b0;
        n = 0;
        while (seen.size() < 9 && n < LIMIT) begin
            @(negedge clk);
            n++;
            if (reset_prev) check_value("timeout digit", segs_ref[0], seg_countdown);
            reset_prev = mode_reset;
            if (seg_countdown != last_seg && seg_countdown != segs_ref[15]) begin
                seen.push_back(seg_countdown);
            end
            last_seg = seg_countdown;
            if (seg_countdown != segs_ref[15] && seg_countdown != segs_ref[0]) begin
                want = expected_outputs(3'd2, 1'b1, 4'd7);
                check_value("error seg_display", want[17:11], seg_display);
                check_value("error led_status", want[3:0], led_status);
            end
        end
        if (seen.size() < 9) abort_run("countdown restart at 7");
        for (int i = 0; i < 9; i++) begin
            want = expected_outputs(3'd2, i != 7, (i == 8) ? 4'd7 : 4'(7 - i));
            check_value($sformatf("countdown step %0d", i), want[10:4], seen[i]);
        end
        check_value("mode_reset pulses", 1, reset_pulses - start_count);
        end_test();

        start_test("error_clear");
        n = 0;
        while (seg_countdown !== segs_ref[4] && n < LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (seg_countdown !== segs_ref[4]) abort_run("countdown digit 4");
        next_slot();
        error_code = ERR_NONE;
        exp_mode   = 3'd2;
        compare_for(4);
        press_button(1'b1);
        wait_for_mode(3'd0);
        exp_mode    = 3'd0;
        error_code  = 4'hA;
        start_count = reset_pulses;
        compare_for(100);
        check_value("menu mode_reset", 0, reset_pulses - start_count);
        end_test();

        errors += u_dut.u_mode_control.u_mode_sva.assert_failures;
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
design/panel_pkg.sv
design/timing_pkg.sv
design/button_debounce.sv
design/mode_control.sv
design/error_countdown.sv
design/status_display.sv
design/front_panel_top.sv
sim/tb_clock_gen.sv
sim/front_panel_sva.sv
sim/front_panel_tb.sv
